// File: rtl/icache_fsm.sv
//========================================
// controller of the cache
// one transition per cycle at most
// refill and uncached paths are exclusive
//========================================

`timescale 1ns/1ps

module icache_fsm (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     req_pending,
    input  logic                     req_cached,
    input  logic                     cache_hit,
    input  logic                     stall,
    input  logic                     rd_rdy,
    input  logic                     unc_rdy,
    input  logic                     unc_ret_valid,
    input  logic                     line_valid,
    output icache_pkg::cache_state_t state,
    output logic                     rd_req,
    output logic                     unc_req,
    output logic                     refill_start,
    output logic                     fill
);
    import icache_pkg::*;

    cache_state_t state_next;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= lookup;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            lookup: begin
                if (req_pending && !req_cached) begin
                    state_next = icache_pkg::unc_req; // enum value, the port shares the name
                end else if (req_pending && !cache_hit) begin
                    state_next = miss_req;
                end
            end
            miss_req: begin
                if (rd_rdy) begin
                    state_next = refill;
                end
            end
            refill: begin
                if (line_valid) begin
                    state_next = refill_done;
                end
            end
            refill_done: begin
                state_next = lookup; // arrays reread here, lookup then hits
            end
            icache_pkg::unc_req: begin
                if (unc_rdy) begin
                    state_next = unc_wait;
                end
            end
            unc_wait: begin
                if (unc_ret_valid) begin
                    state_next = unc_done;
                end
            end
            unc_done: begin
                // word stays on rdata until the fetch stage moves on
                if (!stall) begin
                    state_next = lookup;
                end
            end
            default: begin
                state_next = lookup;
            end
        endcase
    end

    // plain levels toward the memory side
    assign rd_req  = (state == miss_req);
    assign unc_req = (state == icache_pkg::unc_req);

    // refill counter restarts as the line request is taken
    assign refill_start = (state == miss_req) && rd_rdy;

    // write strobe for the victim way and the PLRU
    assign fill = (state == refill) && line_valid;

endmodule

// File: rtl/icache_pkg.sv
//========================================
// geometry of the instruction cache
// fixed here, no module overrides it
// addresses are physical, word aligned
//========================================

package icache_pkg;

    localparam int addr_w     = 32;
    localparam int data_w     = 32;
    localparam int line_words = 4;
    localparam int num_ways   = 4;
    localparam int num_sets   = 16;

    // address split: tag | index | offset
    localparam int offset_w   = $clog2(line_words * data_w / 8);
    localparam int index_w    = $clog2(num_sets);
    localparam int tag_w      = addr_w - index_w - offset_w;
    localparam int word_sel_w = $clog2(line_words);
    localparam int way_w      = $clog2(num_ways);

    typedef struct packed {
        logic             valid;
        logic [tag_w-1:0] tag;
    } tagv_t;

    typedef logic [line_words-1:0][data_w-1:0] line_t; // word 0 in the low bits

    typedef enum logic [2:0] {
        lookup,
        miss_req,
        refill,
        refill_done,
        unc_req,
        unc_wait,
        unc_done
    } cache_state_t;

endpackage

// File: rtl/icache_plru.sv
//========================================
// tree pseudo-LRU, three bits per set
// bit 0 picks the half, bits 1/2 the way
// victim is combinational from index
//========================================

`timescale 1ns/1ps

module icache_plru (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [icache_pkg::index_w-1:0] index,
    input  logic [icache_pkg::way_w-1:0]   hit_way,
    input  logic                           hit,
    input  logic                           fill,
    output logic [icache_pkg::way_w-1:0]   victim
);
    import icache_pkg::*;

    logic [num_sets-1:0][2:0] tree_q;
    logic [2:0]               node;
    logic [2:0]               node_next;
    logic [way_w-1:0]         touch_way;

    assign node = tree_q[index];

    // bit set means the upper way of that pair is older
    assign victim = node[0] ? {1'b1, node[2]} : {1'b0, node[1]};

    // a fill lands in the victim way
    assign touch_way = fill ? victim : hit_way;

    // point every node on the path away from the touched way
    always_comb begin
        node_next    = node;
        node_next[0] = ~touch_way[1];
        if (touch_way[1]) begin
            node_next[2] = ~touch_way[0];
        end else begin
            node_next[1] = ~touch_way[0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tree_q <= '0;
        end else if (hit || fill) begin
            tree_q[index] <= node_next;
        end
    end

endmodule

// File: rtl/icache_ram.sv
//========================================
// single port array, one cycle read
// read reg holds while rd_en is low
// write data is not forwarded to rdata
//========================================

`timescale 1ns/1ps

module icache_ram #(
    parameter type payload_t = icache_pkg::tagv_t
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           rd_en,
    input  logic                           we,
    input  logic [icache_pkg::index_w-1:0] addr,
    input  payload_t                       wdata,
    output payload_t                       rdata
);
    import icache_pkg::*;

    localparam int depth = num_sets;

    payload_t mem [depth];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // read register doubles as the pipeline latch of the lookup
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rdata <= '0;
        end else if (rd_en) begin
            rdata <= mem[addr];
        end
    end

endmodule

// File: rtl/icache_refill_cnt.sv
//========================================
// collects refill beats into one line
// words must arrive in ascending order
// line_valid one cycle after last beat
//========================================

`timescale 1ns/1ps

module icache_refill_cnt (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start,
    input  logic                          ret_valid,
    input  logic [icache_pkg::data_w-1:0] ret_data,
    output icache_pkg::line_t             line,
    output logic                          line_valid
);
    import icache_pkg::*;

    logic [word_sel_w-1:0] beat_cnt;
    logic                  last_beat;

    assign last_beat = (beat_cnt == word_sel_w'(line_words - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            beat_cnt   <= '0;
            line_valid <= 1'b0;
        end else begin
            line_valid <= 1'b0;
            if (start) begin
                beat_cnt <= '0;
            end else if (ret_valid) begin
                beat_cnt   <= beat_cnt + 1'b1; // wraps back to zero
                line_valid <= last_beat;
            end
        end
    end

    // line buffer, slot picked by beat count
    always_ff @(posedge clk) begin
        if (ret_valid && !start) begin
            line[beat_cnt] <= ret_data;
        end
    end

endmodule

// File: rtl/icache_top.sv
//========================================
// 4-way instruction cache, 16 sets
// fetch side holds stall while busy
// busy high for 16 cycles after reset
// no writes, no invalidate, physical addr
//========================================

`timescale 1ns/1ps

module icache_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          req_valid,
    input  logic [icache_pkg::addr_w-1:0] req_addr,
    input  logic                          req_cached,
    input  logic                          stall,
    output logic                          busy,
    output logic [icache_pkg::data_w-1:0] rdata,
    output logic                          rd_req,
    output logic [icache_pkg::addr_w-1:0] rd_addr,
    input  logic                          rd_rdy,
    input  logic                          ret_valid,
    input  logic [icache_pkg::data_w-1:0] ret_data,
    output logic                          unc_req,
    output logic [icache_pkg::addr_w-1:0] unc_addr,
    input  logic                          unc_rdy,
    input  logic                          unc_ret_valid,
    input  logic [icache_pkg::data_w-1:0] unc_ret_data
);
    import icache_pkg::*;

    localparam int byte_w = offset_w - word_sel_w;

    cache_state_t          state;
    logic                  refill_start;
    logic                  fill;
    logic                  line_valid;
    line_t                 refill_line;
    logic                  req_valid_q;
    logic                  req_cached_q;
    logic [addr_w-1:0]     req_addr_q;
    logic [tag_w-1:0]      req_tag;
    logic [index_w-1:0]    req_index;
    logic [word_sel_w-1:0] req_word;
    logic                  init_busy;
    logic [index_w-1:0]    init_cnt;
    logic [index_w-1:0]    array_addr;
    logic                  array_rd_en;
    tagv_t                 tagv_wdata;
    tagv_t                 tagv_rd [num_ways];
    line_t                 data_rd [num_ways];
    logic [num_ways-1:0]   tag_we;
    logic [num_ways-1:0]   data_we;
    logic [num_ways-1:0]   hit;
    logic [data_w-1:0]     way_word [num_ways];
    logic                  cache_hit;
    logic [way_w-1:0]      hit_way;
    logic [way_w-1:0]      victim;
    logic                  plru_hit;
    logic [data_w-1:0]     unc_data_q;

    // request register, frozen by stall
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_valid_q  <= 1'b0;
            req_cached_q <= 1'b0;
        end else if (!stall) begin
            req_valid_q  <= req_valid;
            req_cached_q <= req_cached;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            req_addr_q <= req_addr;
        end
    end

    assign req_tag   = req_addr_q[addr_w-1 -: tag_w];
    assign req_index = req_addr_q[offset_w +: index_w];
    assign req_word  = req_addr_q[byte_w +: word_sel_w];

    // init sweep writes an invalid tag into every set
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            init_busy <= 1'b1;
            init_cnt  <= '0;
        end else if (init_busy) begin
            init_cnt <= init_cnt + 1'b1;
            if (init_cnt == index_w'(num_sets - 1)) begin
                init_busy <= 1'b0;
            end
        end
    end

    always_comb begin
        if (init_busy) begin
            array_addr = init_cnt;
        end else if (state == refill || state == refill_done) begin
            array_addr = req_index;
        end else begin
            array_addr = req_addr[offset_w +: index_w]; // incoming index
        end
    end

    // tag latch and data read enable share this
    assign array_rd_en = !stall || (state == refill_done);
    assign tagv_wdata  = init_busy ? '0 : {1'b1, req_tag};

    for (genvar w = 0; w < num_ways; w++) begin : g_way
        assign tag_we[w]   = init_busy || (fill && victim == way_w'(w));
        assign data_we[w]  = fill && victim == way_w'(w);
        assign hit[w]      = tagv_rd[w].valid && (tagv_rd[w].tag == req_tag);
        assign way_word[w] = data_rd[w][req_word];

        icache_ram #(.payload_t(tagv_t)) tag_ram (
            .clk   (clk),
            .rst_n (rst_n),
            .rd_en (array_rd_en),
            .we    (tag_we[w]),
            .addr  (array_addr),
            .wdata (tagv_wdata),
            .rdata (tagv_rd[w])
        );

        icache_ram #(.payload_t(line_t)) data_ram (
            .clk   (clk),
            .rst_n (rst_n),
            .rd_en (array_rd_en),
            .we    (data_we[w]),
            .addr  (array_addr),
            .wdata (refill_line),
            .rdata (data_rd[w])
        );
    end

    assign cache_hit = |hit;

    // at most one way matches
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (hit[w]) begin
                hit_way = way_w'(w);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (unc_ret_valid) begin
            unc_data_q <= unc_ret_data;
        end
    end

    assign plru_hit = (state == lookup) && req_valid_q && req_cached_q && cache_hit;

    assign rdata = !req_valid_q ? '0 :
                   (state == unc_done) ? unc_data_q : way_word[hit_way];

    assign busy = init_busy
                | (req_valid_q && req_cached_q && !cache_hit)
                | (req_valid_q && !req_cached_q && state != unc_done);

    assign rd_addr  = {req_tag, req_index, {offset_w{1'b0}}}; // line aligned
    assign unc_addr = req_addr_q;

    icache_plru plru_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .index   (req_index),
        .hit_way (hit_way),
        .hit     (plru_hit),
        .fill    (fill),
        .victim  (victim)
    );

    icache_refill_cnt refill_cnt_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (refill_start),
        .ret_valid  (ret_valid),
        .ret_data   (ret_data),
        .line       (refill_line),
        .line_valid (line_valid)
    );

    icache_fsm fsm_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_pending   (req_valid_q),
        .req_cached    (req_cached_q),
        .cache_hit     (cache_hit),
        .stall         (stall),
        .rd_rdy        (rd_rdy),
        .unc_rdy       (unc_rdy),
        .unc_ret_valid (unc_ret_valid),
        .line_valid    (line_valid),
        .state         (state),
        .rd_req        (rd_req),
        .unc_req       (unc_req),
        .refill_start  (refill_start),
        .fill          (fill)
    );

endmodule

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module icache_tb -f tb.f -o icache_sim
./obj_dir/icache_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "test failed" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation PASSED"

// File: sim/icache_mem_model.sv
//========================================
// memory behind both cache ports
// data of a word is its word address
// xor 5a5a_0000, latency 1 to 7 cycles
//========================================

`timescale 1ns/1ps

module icache_mem_model (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [2:0]                    latency,
    input  logic                          rd_req,
    input  logic [icache_pkg::addr_w-1:0] rd_addr,
    output logic                          rd_rdy,
    output logic                          ret_valid,
    output logic [icache_pkg::data_w-1:0] ret_data,
    input  logic                          unc_req,
    input  logic [icache_pkg::addr_w-1:0] unc_addr,
    output logic                          unc_rdy,
    output logic                          unc_ret_valid,
    output logic [icache_pkg::data_w-1:0] unc_ret_data,
    output int                            refill_count,
    output int                            unc_count
);
    import icache_pkg::*;

    typedef enum logic [2:0] {m_idle, m_rd_wait, m_rd_beat, m_unc_wait, m_unc_ret} mem_state_t;

    mem_state_t        mstate;
    logic [addr_w-1:0] base;
    int                wait_cnt;
    int                beat;

    function automatic logic [data_w-1:0] word_at(logic [addr_w-1:0] a);
        return (a >> 2) ^ 32'h5a5a_0000;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mstate        <= m_idle;
            rd_rdy        <= 1'b0;
            ret_valid     <= 1'b0;
            unc_rdy       <= 1'b0;
            unc_ret_valid <= 1'b0;
            refill_count  <= 0;
            unc_count     <= 0;
        end else begin
            rd_rdy        <= 1'b0; // all strobes are one cycle
            ret_valid     <= 1'b0;
            unc_rdy       <= 1'b0;
            unc_ret_valid <= 1'b0;
            case (mstate)
                m_idle: begin
                    wait_cnt <= int'(latency) - 1;
                    if (rd_req) begin
                        base   <= rd_addr;
                        mstate <= m_rd_wait;
                    end else if (unc_req) begin
                        base   <= unc_addr;
                        mstate <= m_unc_wait;
                    end
                end
                m_rd_wait: begin
                    if (wait_cnt == 0) begin
                        rd_rdy       <= 1'b1;
                        refill_count <= refill_count + 1;
                        beat         <= 0;
                        wait_cnt     <= int'(latency) - 1;
                        mstate       <= m_rd_beat;
                    end else begin
                        wait_cnt <= wait_cnt - 1;
                    end
                end
                m_rd_beat: begin
                    if (wait_cnt == 0) begin
                        ret_valid <= 1'b1;
                        ret_data  <= word_at(base + addr_w'(beat * 4));
                        beat      <= beat + 1;
                        wait_cnt  <= int'(latency) - 1; // gap before the next beat
                        if (beat == line_words - 1) begin
                            mstate <= m_idle;
                        end
                    end else begin
                        wait_cnt <= wait_cnt - 1;
                    end
                end
                m_unc_wait: begin
                    if (wait_cnt == 0) begin
                        unc_rdy   <= 1'b1;
                        unc_count <= unc_count + 1;
                        wait_cnt  <= int'(latency) - 1;
                        mstate    <= m_unc_ret;
                    end else begin
                        wait_cnt <= wait_cnt - 1;
                    end
                end
                default: begin
                    if (wait_cnt == 0) begin
                        unc_ret_valid <= 1'b1;
                        unc_ret_data  <= word_at(base);
                        mstate        <= m_idle;
                    end else begin
                        wait_cnt <= wait_cnt - 1;
                    end
                end
            endcase
        end
    end

endmodule

// File: sim/icache_tb.sv
//========================================
// directed and random fetches
// stops at the first mismatch
// PLRU and tag model predict refills
//========================================

`timescale 1ns/1ps

module icache_tb;
    import icache_pkg::*;

    localparam int busy_limit = 200;

    logic              clk;
    logic              rst_n;
    logic              req_valid;
    logic [addr_w-1:0] req_addr;
    logic              req_cached;
    logic              stall;
    logic              busy;
    logic [data_w-1:0] rdata;
    logic              rd_req;
    logic [addr_w-1:0] rd_addr;
    logic              rd_rdy;
    logic              ret_valid;
    logic [data_w-1:0] ret_data;
    logic              unc_req;
    logic [addr_w-1:0] unc_addr;
    logic              unc_rdy;
    logic              unc_ret_valid;
    logic [data_w-1:0] unc_ret_data;
    logic [2:0]        mem_latency;
    int                refill_count;
    int                unc_count;
    int                exp_refills;
    int                exp_unc;
    logic [31:0]       lfsr_state = 32'h365c_effc;

    // stimulus table, one entry per fetch
    logic [addr_w-1:0] tab_addr [$];
    bit                tab_cached [$];
    int                tab_refill [$]; // -1 means the model decides

    // reference of the cache contents
    bit                model_valid [num_sets][num_ways];
    logic [tag_w-1:0]  model_tag [num_sets][num_ways];
    logic [2:0]        model_tree [num_sets];

    icache_top icache_top_inst (.*);

    icache_mem_model icache_mem_model (
        .clk(clk), .rst_n(rst_n), .latency(mem_latency),
        .rd_req(rd_req), .rd_addr(rd_addr), .rd_rdy(rd_rdy),
        .ret_valid(ret_valid), .ret_data(ret_data),
        .unc_req(unc_req), .unc_addr(unc_addr), .unc_rdy(unc_rdy),
        .unc_ret_valid(unc_ret_valid), .unc_ret_data(unc_ret_data),
        .refill_count(refill_count), .unc_count(unc_count)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic next_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return b;
    endfunction

    function automatic logic [31:0] take_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    function automatic logic [data_w-1:0] expected_word(logic [addr_w-1:0] a);
        return (a >> 2) ^ 32'h5a5a_0000;
    endfunction

    // root 0 -> lower half is older; node 1/2 set -> odd way older
    function automatic int pick_victim(logic [2:0] t);
        return t[0] ? (t[2] ? 3 : 2) : (t[1] ? 1 : 0);
    endfunction

    function automatic logic [2:0] touch_tree(logic [2:0] t, int way);
        logic [2:0] n;
        n = t;
        n[0] = (way < 2); // other half becomes the older one
        if (way < 2) begin
            n[1] = (way == 0);
        end else begin
            n[2] = (way == 2);
        end
        return n;
    endfunction

    function automatic int predict_refill(logic [addr_w-1:0] a);
        logic [tag_w-1:0]   tag;
        logic [index_w-1:0] set;
        int                 way;
        int                 refill;
        tag    = a[addr_w-1 -: tag_w];
        set    = a[offset_w +: index_w];
        way    = -1;
        refill = 0;
        for (int w = 0; w < num_ways; w++) begin
            if (model_valid[set][w] && model_tag[set][w] == tag) begin
                way = w;
            end
        end
        if (way < 0) begin
            way = pick_victim(model_tree[set]);
            model_valid[set][way] = 1'b1;
            model_tag[set][way]   = tag;
            refill = 1;
        end
        model_tree[set] = touch_tree(model_tree[set], way);
        return refill;
    endfunction

    task automatic stop_on_error();
        $display("test failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_word(string name, logic [data_w-1:0] got, logic [data_w-1:0] exp);
        if (got !== exp) begin
            $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_count(string name, int got, int exp);
        if (got != exp) begin
            $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic add_entry(logic [addr_w-1:0] a, bit cached, int refill);
        tab_addr.push_back(a);
        tab_cached.push_back(cached);
        tab_refill.push_back(refill);
    endtask

    task automatic build_table();
        int p;
        add_entry(32'h0000_1000, 1, 1); // cold miss
        add_entry(32'h0000_1004, 1, 0);
        add_entry(32'h0000_1008, 1, 0);
        add_entry(32'h0000_100c, 1, 0);
        add_entry(32'h0000_2344, 0, 0); // uncached, twice
        add_entry(32'h0000_2344, 0, 0);
        add_entry(32'h0001_0030, 1, 1); // five tags in set 3
        add_entry(32'h0002_0030, 1, 1);
        add_entry(32'h0003_0030, 1, 1);
        add_entry(32'h0004_0030, 1, 1);
        add_entry(32'h0005_0034, 1, 1);
        add_entry(32'h0001_0038, 1, 1); // evicted by the fifth
        for (int i = 0; i < 32; i++) begin
            add_entry(32'h0004_0000 | (take_bits(3) << 12) | (take_bits(2) << 4)
                      | (take_bits(2) << 2), 1, -1);
        end
        for (int s = 0; s < num_sets; s++) begin
            model_tree[s] = '0;
            for (int w = 0; w < num_ways; w++) begin
                model_valid[s][w] = 1'b0;
            end
        end
        foreach (tab_addr[i]) begin
            if (tab_cached[i]) begin
                p = predict_refill(tab_addr[i]);
                if (tab_refill[i] < 0) begin
                    tab_refill[i] = p;
                end else if (p != tab_refill[i]) begin
                    $display("reference PLRU disagrees with table entry %0d", i);
                    stop_on_error();
                end
            end
        end
    endtask

    task automatic wait_busy_low(output int cycles);
        bit done;
        cycles = 0;
        done   = 1'b0;
        while (!done) begin
            @(negedge clk);
            cycles++;
            if (!busy) begin
                done = 1'b1;
            end else if (cycles >= busy_limit) begin
                $display("timeout, busy still high after %0d cycles", busy_limit);
                stop_on_error();
            end
        end
    endtask

    task automatic apply_entry(int i);
        int cycles;
        @(posedge clk);
        req_valid   <= 1'b1;
        req_addr    <= tab_addr[i];
        req_cached  <= tab_cached[i];
        stall       <= 1'b0;
        mem_latency <= 3'(take_bits(2) + 1);
        @(posedge clk); // accepted here
        stall     <= 1'b1;
        req_valid <= 1'b0;
        exp_refills += tab_refill[i];
        exp_unc     += tab_cached[i] ? 0 : 1;
        wait_busy_low(cycles);
        if (tab_cached[i] && tab_refill[i] == 0 && cycles != 1) begin
            $display("hit on entry %0d took %0d cycles instead of one", i, cycles);
            stop_on_error();
        end
        check_word("rdata", rdata, expected_word(tab_addr[i]));
        check_count("refill_count", refill_count, exp_refills);
        check_count("unc_count", unc_count, exp_unc);
        @(negedge clk);
        check_word("rdata", rdata, expected_word(tab_addr[i])); // still stalled
    endtask

    initial begin
        int cycles;
        rst_n       = 1'b0;
        req_valid   = 1'b0;
        req_addr    = '0;
        req_cached  = 1'b0;
        stall       = 1'b1;
        mem_latency = 3'd1;
        exp_refills = 0;
        exp_unc     = 0;
        build_table();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        wait_busy_low(cycles); // init sweep
        check_word("rdata", rdata, '0);
        foreach (tab_addr[i]) begin
            apply_entry(i);
        end
        $display("test passed");
        $finish;
    end

endmodule

// File: tb.f
rtl/icache_pkg.sv
rtl/icache_ram.sv
rtl/icache_plru.sv
rtl/icache_refill_cnt.sv
rtl/icache_fsm.sv
rtl/icache_top.sv
sim/icache_mem_model.sv
sim/icache_tb.sv
